// ==== design/hsst_rx_pkg.sv ====
`default_nettype none

package hsst_rx_pkg;

  localparam int LANES = 4;  // byte lanes per link word

  typedef logic [7:0]        byte_t;   // one ad sample or link byte
  typedef logic [31:0]       word_t;   // four bytes, byte 0 in the low bits
  typedef logic [LANES-1:0]  kflag_t;  // one k-flag per byte lane

  // raw or aligned receive word, as delivered by the transceiver
  typedef struct packed {
    word_t  data;  // link payload
    kflag_t k;     // control-character flags
  } rx_word_t;

  localparam byte_t K_COMMA  = 8'hBC;  // k28.5 comma
  localparam byte_t SOF_MARK = 8'h50;  // byte after the comma in a start word

  typedef enum logic {
    IDLE = 1'b0,  // hunting for a start word
    DATA = 1'b1   // collecting sample words
  } frame_state_e;

endpackage

`default_nettype wire

// ==== design/word_align.sv ====
`timescale 1ns/1ps
`default_nettype none

module word_align (
  input  wire logic                  free_clk,
  input  wire logic                  rst_n,
  input  wire hsst_rx_pkg::rx_word_t i_rx,       // raw word from the link
  output hsst_rx_pkg::rx_word_t      o_aligned,  // comma rotated into lane 0
  output logic                       o_locked    // first start word seen
);

  localparam int LW = $clog2(hsst_rx_pkg::LANES);  // lane index width

  typedef logic [LW-1:0] lane_t;   // byte lane number
  typedef logic [LW:0]   shift_t;  // first window byte, 1..LANES

  hsst_rx_pkg::rx_word_t prev_q;      // previous input word
  lane_t                 offset_q;    // comma lane of the last start word
  lane_t                 offset_d;    // offset applied to this word
  lane_t                 comma_lane;  // lane holding the single k-flag
  logic                  is_start;    // exactly one k-flag set
  shift_t                shift;       // window start byte
  hsst_rx_pkg::byte_t [2*hsst_rx_pkg::LANES-1:0] win_data;  // prev low, current high
  logic [2*hsst_rx_pkg::LANES-1:0]               win_k;     // flags, same order
  hsst_rx_pkg::rx_word_t sel;         // rotated word ahead of the flop

  assign is_start = $onehot(i_rx.k);  // start word marker

  // lane of the comma, only meaningful with is_start
  always_comb begin
    comma_lane = '0;
    for (int i = 0; i < hsst_rx_pkg::LANES; i++) begin
      if (i_rx.k[i]) begin
        comma_lane = lane_t'(i);
      end
    end
  end

  assign offset_d = is_start ? comma_lane : offset_q;  // new lane takes effect at once
  // offset 0 takes the current word whole, else tail of prev plus head of current
  assign shift    = (offset_d == '0) ? shift_t'(hsst_rx_pkg::LANES) : shift_t'(offset_d);
  assign win_data = {i_rx.data, prev_q.data};  // 8-byte sliding window
  assign win_k    = {i_rx.k, prev_q.k};

  always_comb begin
    for (int i = 0; i < hsst_rx_pkg::LANES; i++) begin
      sel.data[8*i +: 8] = win_data[shift + i];  // byte i of aligned word
      sel.k[i]           = win_k[shift + i];     // flag follows its byte
    end
  end

  always_ff @(posedge free_clk or negedge rst_n) begin
    if (!rst_n) begin
      prev_q    <= '0;    // all-zero idle word
      offset_q  <= '0;
      o_aligned <= '0;
      o_locked  <= 1'b0;
    end else begin
      prev_q    <= i_rx;
      offset_q  <= offset_d;  // reloads on every start word
      o_aligned <= sel;       // one cycle after the last byte
      if (is_start) begin
        o_locked <= 1'b1;     // sticky until reset
      end
    end
  end

  // lane offset only moves when a start word arrives
  a_offset_hold : assert property (@(posedge free_clk) disable iff (!rst_n)
    !is_start |=> $stable(offset_q))
    else $error("word_align: lane offset changed without a start word");

endmodule

`default_nettype wire

// ==== design/frame_unpack.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_unpack #(
  parameter int FRAME_WORDS = 4  // data words after each start word
) (
  input  wire logic                  free_clk,
  input  wire logic                  rst_n,
  input  wire hsst_rx_pkg::rx_word_t i_aligned,   // comma in lane 0
  output logic                       o_wr_en,     // sample word strobe
  output hsst_rx_pkg::word_t         o_wr_data,   // four samples, byte 0 first
  output logic                       o_frame_err  // k-flag inside a frame
);

  localparam int CW = $clog2(FRAME_WORDS + 1);  // counter width

  typedef logic [CW-1:0] cnt_t;  // data word index in a frame

  localparam cnt_t LAST = cnt_t'(FRAME_WORDS - 1);  // index of final data word

  hsst_rx_pkg::frame_state_e state_q;  // current frame state
  hsst_rx_pkg::frame_state_e state_d;
  cnt_t                      cnt_q;    // data words taken so far
  cnt_t                      cnt_d;
  logic                      is_sof;   // valid start word
  logic                      has_k;    // any control byte
  logic                      wr_d;     // write next cycle
  logic                      err_d;    // error next cycle

  assign has_k  = |i_aligned.k;
  assign is_sof = (i_aligned.k == hsst_rx_pkg::kflag_t'(1)) &&          // comma lane 0 only
                  (i_aligned.data[7:0] == hsst_rx_pkg::K_COMMA) &&
                  (i_aligned.data[15:8] == hsst_rx_pkg::SOF_MARK);    // sof follows comma

  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    wr_d    = 1'b0;
    err_d   = 1'b0;
    case (state_q)
      hsst_rx_pkg::IDLE: begin
        if (is_sof) begin
          state_d = hsst_rx_pkg::DATA;  // frame opens
          cnt_d   = '0;
        end
      end
      hsst_rx_pkg::DATA: begin
        if (!has_k) begin
          wr_d = 1'b1;                  // plain data word
          if (cnt_q == LAST) begin
            state_d = hsst_rx_pkg::IDLE;  // frame complete
            cnt_d   = '0;
          end else begin
            cnt_d = cnt_q + 1'b1;
          end
        end else begin
          err_d = 1'b1;                 // broken frame, written words stay
          cnt_d = '0;
          if (is_sof) begin
            state_d = hsst_rx_pkg::DATA;  // new frame starts right here
          end else begin
            state_d = hsst_rx_pkg::IDLE;
          end
        end
      end
      default: begin
        state_d = hsst_rx_pkg::IDLE;
        cnt_d   = '0;
      end
    endcase
  end

  always_ff @(posedge free_clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= hsst_rx_pkg::IDLE;
      cnt_q       <= '0;
      o_wr_en     <= 1'b0;
      o_frame_err <= 1'b0;
    end else begin
      state_q     <= state_d;
      cnt_q       <= cnt_d;
      o_wr_en     <= wr_d;   // registered strobe
      o_frame_err <= err_d;  // one-cycle pulse
    end
  end

  always_ff @(posedge free_clk) begin
    o_wr_data <= i_aligned.data;  // samples qualified by o_wr_en
  end

  // word index stays inside one frame
  a_cnt_range : assert property (@(posedge free_clk) disable iff (!rst_n)
    cnt_q <= LAST)
    else $error("frame_unpack: word counter ran past the frame length");

endmodule

`default_nettype wire

// ==== design/sample_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module sample_fifo #(
  parameter int FIFO_DEPTH = 16  // words, power of two
) (
  input  wire logic                free_clk,
  input  wire logic                rst_n,
  input  wire logic                i_wr_en,     // push request
  input  wire hsst_rx_pkg::word_t  i_wr_data,
  input  wire logic                i_rd_en,     // pop request
  output hsst_rx_pkg::word_t       o_rd_data,   // valid with o_rd_valid
  output logic                     o_rd_valid,
  output logic                     o_empty,
  output logic                     o_full
);

  localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;  // address width

  typedef logic [AW:0]   ptr_t;   // address plus wrap bit
  typedef logic [AW-1:0] addr_t;  // storage index

  hsst_rx_pkg::word_t mem [FIFO_DEPTH];  // sample storage
  ptr_t               wr_ptr_q;          // next slot to write
  ptr_t               rd_ptr_q;          // next slot to read
  addr_t              wr_addr;
  addr_t              rd_addr;
  logic               wr_ok;             // accepted write
  logic               rd_ok;             // accepted read

  assign wr_addr = wr_ptr_q[AW-1:0];
  assign rd_addr = rd_ptr_q[AW-1:0];

  // flags follow the pointer registers, so they move the cycle after
  assign o_empty = (wr_ptr_q == rd_ptr_q);
  assign o_full  = (wr_ptr_q[AW] != rd_ptr_q[AW]) && (wr_addr == rd_addr);  // wrap differs

  assign wr_ok = i_wr_en && !o_full;   // drop when full
  assign rd_ok = i_rd_en && !o_empty;  // ignore when empty

  always_ff @(posedge free_clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      o_rd_valid <= 1'b0;
    end else begin
      if (wr_ok) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (rd_ok) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      o_rd_valid <= rd_ok;  // read data one cycle later
    end
  end

  always_ff @(posedge free_clk) begin
    if (wr_ok) begin
      mem[wr_addr] <= i_wr_data;
    end
    if (rd_ok) begin
      o_rd_data <= mem[rd_addr];  // registered read port
    end
  end

  // pointer arithmetic never reports both states
  a_flags_excl : assert property (@(posedge free_clk) disable iff (!rst_n)
    !(o_full && o_empty))
    else $error("sample_fifo: full and empty asserted together");

endmodule

`default_nettype wire

// ==== design/send_trigger.sv ====
`timescale 1ns/1ps
`default_nettype none

module send_trigger #(
  parameter int KEY_PULSE_AT = 500000,   // timer value that fires the pulse
  parameter int KEY_HOLD_MAX = 2500000   // timer saturation
) (
  input  wire logic free_clk,
  input  wire logic rst_n,
  input  wire logic i_key,        // raw send key, async
  input  wire logic i_buf_full,   // sample buffer full
  output logic      o_send_start  // one-cycle start request
);

  localparam int TW = $clog2(KEY_HOLD_MAX + 1);  // timer width

  typedef logic [TW-1:0] timer_t;  // cycles since key release

  logic   key_d0;   // first sync stage
  logic   key_d1;   // synchronised key
  timer_t timer_q;  // hold timer
  logic   pulse_q;  // timer reached the mark

  always_ff @(posedge free_clk or negedge rst_n) begin
    if (!rst_n) begin
      key_d0 <= 1'b0;
      key_d1 <= 1'b0;
    end else begin
      key_d0 <= i_key;   // may go metastable
      key_d1 <= key_d0;
    end
  end

  always_ff @(posedge free_clk or negedge rst_n) begin
    if (!rst_n) begin
      timer_q <= '0;  // counts from reset, so one pulse follows it
    end else if (key_d1) begin
      timer_q <= '0;  // restart while pressed
    end else if (timer_q >= timer_t'(KEY_HOLD_MAX)) begin
      timer_q <= timer_q;  // saturate
    end else begin
      timer_q <= timer_q + 1'b1;
    end
  end

  always_ff @(posedge free_clk or negedge rst_n) begin
    if (!rst_n) begin
      pulse_q <= 1'b0;
    end else begin
      pulse_q <= (timer_q == timer_t'(KEY_PULSE_AT));  // cycle after the mark
    end
  end

  assign o_send_start = pulse_q & i_buf_full;  // only with a full buffer

  // timer passes the mark once per release
  a_single_pulse : assert property (@(posedge free_clk) disable iff (!rst_n)
    o_send_start |=> !o_send_start)
    else $error("send_trigger: start pulse longer than one cycle");

endmodule

`default_nettype wire

// ==== design/hsst_rx_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module hsst_rx_top #(
  parameter int FRAME_WORDS  = 4,        // data words per frame
  parameter int FIFO_DEPTH   = 16,       // buffer words, power of two
  parameter int KEY_PULSE_AT = 500000,   // send pulse mark
  parameter int KEY_HOLD_MAX = 2500000   // send timer saturation
) (
  input  wire logic                  free_clk,
  input  wire logic                  rst_n,
  input  wire hsst_rx_pkg::rx_word_t i_rx,          // receive lane, one word per cycle
  input  wire logic                  i_key_send,    // send key
  input  wire logic                  i_rd_en,       // buffer pop
  output hsst_rx_pkg::word_t         o_rd_data,
  output logic                       o_rd_valid,
  output logic                       o_empty,
  output logic                       o_full,
  output logic                       o_locked,      // alignment found
  output logic                       o_frame_err,   // broken frame pulse
  output logic                       o_send_start   // start send request
);

  hsst_rx_pkg::rx_word_t aligned;  // word_align to frame_unpack
  logic                  wr_en;    // sample word strobe
  hsst_rx_pkg::word_t    wr_data;  // four samples

  word_align u_word_align (
    .free_clk  (free_clk),
    .rst_n     (rst_n),
    .i_rx      (i_rx),
    .o_aligned (aligned),
    .o_locked  (o_locked)
  );

  frame_unpack #(
    .FRAME_WORDS (FRAME_WORDS)
  ) u_frame_unpack (
    .free_clk    (free_clk),
    .rst_n       (rst_n),
    .i_aligned   (aligned),
    .o_wr_en     (wr_en),
    .o_wr_data   (wr_data),
    .o_frame_err (o_frame_err)
  );

  sample_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_sample_fifo (
    .free_clk   (free_clk),
    .rst_n      (rst_n),
    .i_wr_en    (wr_en),
    .i_wr_data  (wr_data),
    .i_rd_en    (i_rd_en),
    .o_rd_data  (o_rd_data),
    .o_rd_valid (o_rd_valid),
    .o_empty    (o_empty),
    .o_full     (o_full)       // also gates the send pulse
  );

  send_trigger #(
    .KEY_PULSE_AT (KEY_PULSE_AT),
    .KEY_HOLD_MAX (KEY_HOLD_MAX)
  ) u_send_trigger (
    .free_clk     (free_clk),
    .rst_n        (rst_n),
    .i_key        (i_key_send),
    .i_buf_full   (o_full),
    .o_send_start (o_send_start)
  );

endmodule

`default_nettype wire

// ==== tb/tb_hsst_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_hsst_rx;

  localparam int FRAME_WORDS  = 4;
  localparam int FIFO_DEPTH   = 8;
  localparam int KEY_PULSE_AT = 20;
  localparam int KEY_HOLD_MAX = 100;
  localparam int MAX_CMDS     = 256;

  logic                  free_clk;
  logic                  rst_n;
  hsst_rx_pkg::rx_word_t i_rx;
  logic                  i_key_send;
  logic                  i_rd_en;
  hsst_rx_pkg::word_t    o_rd_data;
  logic                  o_rd_valid;
  logic                  o_empty;
  logic                  o_full;
  logic                  o_locked;
  logic                  o_frame_err;
  logic                  o_send_start;

  byte         ops [MAX_CMDS];     // opcode per command
  logic [31:0] fld [MAX_CMDS][7];  // hex fields per command
  int          ncmd = 0;
  int          seed = 32'h82161c3e;
  int          cycles = 0;
  int          limit = 32'h7fffffff;  // real value set after parsing
  int          err_cnt = 0;           // frame error pulses since last check
  int          send_cnt = 0;          // send pulses since last check
  logic [31:0] exp_q [$];             // expected sample words

  hsst_rx_top #(
    .FRAME_WORDS  (FRAME_WORDS),
    .FIFO_DEPTH   (FIFO_DEPTH),
    .KEY_PULSE_AT (KEY_PULSE_AT),
    .KEY_HOLD_MAX (KEY_HOLD_MAX)
  ) u_dut (
    .free_clk     (free_clk),
    .rst_n        (rst_n),
    .i_rx         (i_rx),
    .i_key_send   (i_key_send),
    .i_rd_en      (i_rd_en),
    .o_rd_data    (o_rd_data),
    .o_rd_valid   (o_rd_valid),
    .o_empty      (o_empty),
    .o_full       (o_full),
    .o_locked     (o_locked),
    .o_frame_err  (o_frame_err),
    .o_send_start (o_send_start)
  );

  initial begin
    free_clk = 1'b0;
    forever #2 free_clk = ~free_clk;  // 4 ns period
  end

  // pulses sampled mid-cycle, away from the drive edge
  always @(negedge free_clk) begin
    if (rst_n && o_frame_err) err_cnt++;
    if (rst_n && o_send_start) send_cnt++;
  end

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "run stopped");
  endtask

  always @(posedge free_clk) begin
    cycles++;
    if (cycles > limit) begin
      stop_run($sformatf("timeout: the run went past its cycle limit of %0d", limit));
    end
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR: %s got 0x%h expected 0x%h", name, got, exp);
      $display("** FAIL **");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic send_word(input logic [31:0] d, input logic [3:0] k);
    @(posedge free_clk);
    i_rx.data <= d;
    i_rx.k    <= k;
  endtask

  // start word at lane off, then the data words, zero padded to a word edge
  task automatic send_frame(input int c);
    logic [7:0]  bs [32];
    logic        kb [32];
    logic [31:0] w;
    logic [31:0] d;
    logic [3:0]  k;
    int          off;
    int          nw;
    off = fld[c][0];
    for (int i = 0; i < 32; i++) begin
      bs[i] = 8'h00;
      kb[i] = 1'b0;
    end
    bs[off]     = hsst_rx_pkg::K_COMMA;
    kb[off]     = 1'b1;               // only the comma is a control byte
    bs[off + 1] = hsst_rx_pkg::SOF_MARK;
    for (int j = 0; j < FRAME_WORDS; j++) begin
      w = (fld[c][1] != 0) ? $random(seed) : fld[c][3 + j];
      if (fld[c][2] != 0) exp_q.push_back(w);  // kept frames only
      for (int b = 0; b < 4; b++) bs[off + 4 + 4*j + b] = w[8*b +: 8];  // byte 0 first
    end
    nw = (off + 4 + 4*FRAME_WORDS + 3) / 4;
    for (int i = 0; i < nw; i++) begin
      for (int b = 0; b < 4; b++) begin
        d[8*b +: 8] = bs[4*i + b];
        k[b]        = kb[4*i + b];
      end
      send_word(d, k);
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) send_word(32'h0, 4'h0);  // all-zero idle words
  endtask

  task automatic press_key(input int n);
    @(posedge free_clk);
    i_key_send <= 1'b1;
    i_rx       <= '0;
    repeat (n) @(posedge free_clk);
    i_key_send <= 1'b0;
  endtask

  task automatic pop_check(input logic [31:0] exp);
    int t;
    t = 0;
    @(posedge free_clk);
    i_rd_en <= 1'b1;
    i_rx    <= '0;
    @(posedge free_clk);
    i_rd_en <= 1'b0;
    @(posedge free_clk);
    while (!o_rd_valid) begin
      t++;
      if (t > 8) begin
        stop_run("read from the sample buffer returned no data");
      end
      @(posedge free_clk);
    end
    check_value("o_rd_data", o_rd_data, exp);
  endtask

  task automatic expect_flag(input int id, input logic [31:0] v);
    @(posedge free_clk);
    case (id)
      0: check_value("o_empty", o_empty, v);
      1: check_value("o_full", o_full, v);
      2: check_value("o_locked", o_locked, v);
      3: check_value("o_rd_valid", o_rd_valid, v);
      4: begin
        check_value("o_frame_err pulses", err_cnt, v);
        err_cnt = 0;
      end
      5: begin
        check_value("o_send_start pulses", send_cnt, v);
        send_cnt = 0;
      end
      default: stop_run("unknown flag id in the pattern file");
    endcase
  endtask

  function automatic int field_count(input byte op);
    case (op)
      "W", "R", "E": return 2;
      "F": return 3 + FRAME_WORDS;  // off rnd keep words
      "I", "P": return 1;
      default: return -1;
    endcase
  endfunction

  initial begin
    int          fd;
    int          rc;
    int          nf;
    int          total;
    byte         ch;
    logic [8*256-1:0] line;
    rst_n      = 1'b0;
    i_rx       = '0;
    i_key_send = 1'b0;
    i_rd_en    = 1'b0;
    total      = 0;
    fd = $fopen("tb/hsst_rx_patterns.txt", "r");
    if (fd == 0) begin
      stop_run("could not open the pattern file");
    end
    while (!$feof(fd)) begin
      rc = $fscanf(fd, " %c", ch);
      if (rc != 1) break;
      if (ch == "#") begin
        rc = $fgets(line, fd);  // skip comment text
      end else begin
        nf = field_count(ch);
        if (nf < 0 || ncmd >= MAX_CMDS) begin
          stop_run("bad opcode or too many lines in the pattern file");
        end
        ops[ncmd] = ch;
        for (int i = 0; i < nf; i++) begin
          rc = $fscanf(fd, " %h", fld[ncmd][i]);
          if (rc != 1) begin
            stop_run("a line in the pattern file has too few fields");
          end
        end
        case (ch)  // cycle cost of each command
          "W", "E": total += 1;
          "F": total += FRAME_WORDS + 2;
          "I", "P": total += fld[ncmd][0] + 1;
          "R": total += (fld[ncmd][0] != 0) ? 12 : 12 * fld[ncmd][1];
          default: total += 1;
        endcase
        ncmd++;
      end
    end
    $fclose(fd);
    limit = total + 200;
    repeat (5) @(posedge free_clk);
    rst_n <= 1'b1;
    for (int c = 0; c < ncmd; c++) begin
      case (ops[c])
        "W": send_word(fld[c][0], fld[c][1][3:0]);
        "F": send_frame(c);
        "I": idle_cycles(fld[c][0]);
        "P": press_key(fld[c][0]);
        "R": begin
          if (fld[c][0] != 0) begin
            pop_check(fld[c][1]);  // word given in the line
          end else begin
            repeat (fld[c][1]) begin
              if (exp_q.size() == 0) begin
                stop_run("pattern pops more words than were queued");
              end
              pop_check(exp_q.pop_front());
            end
          end
        end
        "E": expect_flag(fld[c][0], fld[c][1]);
        default: ;
      endcase
    end
    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
design/hsst_rx_pkg.sv
design/word_align.sv
design/frame_unpack.sv
design/sample_fifo.sv
design/send_trigger.sv
design/hsst_rx_top.sv
tb/tb_hsst_rx.sv

// ==== tb/hsst_rx_patterns.txt ====
# W data k | F off rnd keep w0 w1 w2 w3 | I n | P n (all hex)
# R src word (src 1 pops one given word, 0 pops word count from queue) | E id value
E 0 1
E 1 0
E 2 0
E 3 0
E 4 0
E 5 0
F 0 0 1 03020100 07060504 0B0A0908 0F0E0D0C
I 6
E 2 1
R 0 4
F 1 0 1 13121110 17161514 1B1A1918 1F1E1D1C
I 6
R 0 4
F 2 1 1 0 0 0 0
I 6
R 0 4
F 3 0 1 A3A2A1A0 A7A6A5A4 ABAAA9A8 AFAEADAC
I 6
R 0 4
E 0 1
E 4 0
# broken frame, control flags in the third data word
W 000050BC 1
W 11111111 0
W 22222222 0
W 33333333 3
I 4
E 4 1
R 1 11111111
R 1 22222222
F 0 1 1 0 0 0 0
I 6
R 0 4
E 0 1
# fill the buffer, then two dropped frames
F 0 1 1 0 0 0 0
F 0 1 1 0 0 0 0
F 1 1 0 0 0 0 0
F 2 1 0 0 0 0 0
I 6
E 1 1
P 4
I 73
E 5 1
R 0 8
E 0 1
E 1 0
P 4
I 73
E 5 0
